// File: hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int data_width = 32;
	localparam int pc_width = 10;
	localparam int mem_words = 256;
	localparam int reg_count = 32;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// instruction and select encodings
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [4:0] {
		OP_ALU     = 5'd0,
		OP_ADDI    = 5'd1,
		OP_ORI     = 5'd2,
		OP_ADDIU20 = 5'd3,
		OP_SLLI    = 5'd4,
		OP_LWI     = 5'd5,
		OP_SWI     = 5'd6,
		OP_BEQ     = 5'd7,
		OP_J       = 5'd8,
		OP_HALT    = 5'd9
	} opcode_t;

	// for OP_ALU the function sits in instruction bits 2:0, the operand2 form in bits 4:3
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLL = 3'd5
	} alu_op_t;

	typedef enum logic [1:0] {PC_PLUS4, PC_BR14, PC_J24} pc_sel_t;

	typedef enum logic [1:0] {IMM_ZE5, IMM_SE15, IMM_ZE15, IMM_SE20} imm_sel_t;

	typedef enum logic [2:0] {SRC2_RB, SRC2_IMM, SRC2_IMM15_SL2, SRC2_RB_SV, SRC2_RT} src2_sel_t;

	typedef enum logic [1:0] {WB_ALU, WB_OPERAND, WB_MEM} wb_sel_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bundles
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// the immediate fields overlap the register fields in the instruction word
	typedef struct packed {
		opcode_t     op;
		logic [4:0]  rt;
		logic [4:0]  ra;
		logic [4:0]  rb;
		logic [1:0]  sv;
		logic [4:0]  imm5;
		logic [13:0] imm14;
		logic [14:0] imm15;
		logic [19:0] imm20;
		logic [23:0] imm24;
	} instr_fields_t;

	typedef struct packed {
		pc_sel_t   pc_sel;
		imm_sel_t  imm_sel;
		src2_sel_t src2_sel;
		wb_sel_t   wb_sel;
	} mux_ctrl_t;

	typedef struct packed {
		logic                  req;
		logic                  we;
		logic [pc_width-1:0]   addr;
		logic [data_width-1:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic                  valid;
		logic [pc_width-1:0]   pc;
		logic                  we;
		logic [4:0]            rd;
		logic [data_width-1:0] data;
	} retire_t;

endpackage

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
	input  cpu_pkg::alu_op_t               op,
	input  logic [cpu_pkg::data_width-1:0] a,
	input  logic [cpu_pkg::data_width-1:0] b,
	output logic [cpu_pkg::data_width-1:0] result,
	output logic                           zero
);
	import cpu_pkg::*;

	always_comb begin
		case (op)
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_SLL: result = a << b[4:0];
			// unused function codes add
			default: result = a + b;
		endcase
	end

	// BEQ compares through a SUB
	assign zero = (result == '0);

endmodule

`default_nettype wire

// File: hdl/register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [4:0]                     ra_addr,
	input  logic [4:0]                     rb_addr,
	input  logic [4:0]                     rt_addr,
	output logic [cpu_pkg::data_width-1:0] ra_data,
	output logic [cpu_pkg::data_width-1:0] rb_data,
	output logic [cpu_pkg::data_width-1:0] rt_data,
	input  logic                           we,
	input  logic [4:0]                     wr_addr,
	input  logic [cpu_pkg::data_width-1:0] wr_data
);
	import cpu_pkg::*;

	logic [data_width-1:0] regs [reg_count];

	// register 0 is cleared by reset and never written
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
		end else if (we && wr_addr != 5'd0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];
	assign rt_data = regs[rt_addr];

endmodule

`default_nettype wire

// File: hdl/datapath_muxes.sv
`timescale 1ns/1ns
`default_nettype none

module datapath_muxes (
	input  logic [cpu_pkg::pc_width-1:0]   current_pc,
	input  cpu_pkg::instr_fields_t         fields,
	input  cpu_pkg::mux_ctrl_t             ctrl,
	input  logic [cpu_pkg::data_width-1:0] rb_data,
	input  logic [cpu_pkg::data_width-1:0] rt_data,
	input  logic [cpu_pkg::data_width-1:0] mem_rdata,
	input  logic [cpu_pkg::data_width-1:0] alu_result,
	output logic [cpu_pkg::pc_width-1:0]   next_pc,
	output logic [cpu_pkg::data_width-1:0] operand2,
	output logic [cpu_pkg::data_width-1:0] wb_data
);
	import cpu_pkg::*;

	logic [data_width-1:0] imm;
	logic [data_width-1:0] br_off;
	logic [data_width-1:0] jmp_off;

	// offsets are halfword scaled, only the low pc bits survive the add
	assign br_off = {{17{fields.imm14[13]}}, fields.imm14, 1'b0};
	assign jmp_off = {{7{fields.imm24[23]}}, fields.imm24, 1'b0};

	always_comb begin
		case (ctrl.pc_sel)
			PC_BR14: next_pc = current_pc + br_off[pc_width-1:0];
			PC_J24:  next_pc = current_pc + jmp_off[pc_width-1:0];
			default: next_pc = current_pc + pc_width'(4);
		endcase
	end

	always_comb begin
		case (ctrl.imm_sel)
			IMM_ZE5:  imm = {27'b0, fields.imm5};
			IMM_SE15: imm = {{17{fields.imm15[14]}}, fields.imm15};
			IMM_ZE15: imm = {17'b0, fields.imm15};
			IMM_SE20: imm = {{12{fields.imm20[19]}}, fields.imm20};
			default:  imm = '0;
		endcase
	end

	always_comb begin
		case (ctrl.src2_sel)
			SRC2_IMM:       operand2 = imm;
			SRC2_IMM15_SL2: operand2 = {15'b0, fields.imm15, 2'b0};
			SRC2_RB_SV:     operand2 = rb_data << fields.sv;
			SRC2_RT:        operand2 = rt_data;
			default:        operand2 = rb_data;
		endcase
	end

	// immediate moves bypass the ALU through operand2
	always_comb begin
		case (ctrl.wb_sel)
			WB_OPERAND: wb_data = operand2;
			WB_MEM:     wb_data = mem_rdata;
			default:    wb_data = alu_result;
		endcase
	end

	// the decoder in the control FSM falls back to defined selects for any opcode
	always_comb begin
		assert final (!$isunknown(ctrl))
			else $error("datapath select is unknown");
	end

endmodule

`default_nettype wire

// File: hdl/control_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module control_fsm (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           core_run,
	output cpu_pkg::mem_req_t              fetch_req,
	output cpu_pkg::mem_req_t              data_req,
	input  logic                           fetch_grant,
	input  logic                           fetch_rvalid,
	input  logic                           data_grant,
	input  logic                           data_rvalid,
	input  logic [cpu_pkg::data_width-1:0] mem_rdata,
	output cpu_pkg::instr_fields_t         fields,
	output cpu_pkg::mux_ctrl_t             ctrl,
	output cpu_pkg::alu_op_t               alu_op,
	input  logic                           zero,
	input  logic [cpu_pkg::pc_width-1:0]   next_pc,
	output logic [cpu_pkg::pc_width-1:0]   current_pc,
	output logic                           rf_we,
	input  logic [cpu_pkg::data_width-1:0] store_data,
	input  logic [cpu_pkg::data_width-1:0] alu_result,
	input  logic [cpu_pkg::data_width-1:0] wb_data,
	output cpu_pkg::retire_t               retire,
	output logic                           halted
);
	import cpu_pkg::*;

	typedef enum logic [2:0] {IDLE, FETCH, FETCH_WAIT, EXEC, MEM, MEM_WAIT, WB, HALT} state_t;

	state_t state;
	logic [pc_width-1:0] pc;
	logic [data_width-1:0] ir;
	logic [data_width-1:0] wb_q;
	logic writes_rd;
	logic is_load;
	logic is_store;
	logic is_halt;

	always_comb begin
		fields.op = opcode_t'(ir[31:27]);
		fields.rt = ir[24:20];
		fields.ra = ir[19:15];
		fields.rb = ir[14:10];
		fields.sv = ir[9:8];
		fields.imm5 = ir[14:10];
		fields.imm14 = ir[13:0];
		fields.imm15 = ir[14:0];
		fields.imm20 = ir[19:0];
		fields.imm24 = ir[23:0];
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		ctrl.pc_sel = PC_PLUS4;
		ctrl.imm_sel = IMM_SE15;
		ctrl.src2_sel = SRC2_RB;
		ctrl.wb_sel = WB_ALU;
		alu_op = ALU_ADD;
		writes_rd = 1'b0;
		is_load = 1'b0;
		is_store = 1'b0;
		is_halt = 1'b0;
		case (fields.op)
			OP_ALU: begin
				alu_op = alu_op_t'(ir[2:0]);
				case (ir[4:3])
					2'b01:   ctrl.src2_sel = SRC2_RB_SV;
					2'b10:   ctrl.src2_sel = SRC2_RT;
					default: ctrl.src2_sel = SRC2_RB;
				endcase
				writes_rd = 1'b1;
			end
			OP_ADDI: begin
				ctrl.src2_sel = SRC2_IMM;
				writes_rd = 1'b1;
			end
			OP_ORI: begin
				ctrl.imm_sel = IMM_ZE15;
				ctrl.src2_sel = SRC2_IMM;
				alu_op = ALU_OR;
				writes_rd = 1'b1;
			end
			OP_ADDIU20: begin
				ctrl.imm_sel = IMM_SE20;
				ctrl.src2_sel = SRC2_IMM;
				ctrl.wb_sel = WB_OPERAND;
				writes_rd = 1'b1;
			end
			OP_SLLI: begin
				ctrl.imm_sel = IMM_ZE5;
				ctrl.src2_sel = SRC2_IMM;
				alu_op = ALU_SLL;
				writes_rd = 1'b1;
			end
			OP_LWI: begin
				ctrl.src2_sel = SRC2_IMM15_SL2;
				ctrl.wb_sel = WB_MEM;
				writes_rd = 1'b1;
				is_load = 1'b1;
			end
			OP_SWI: begin
				ctrl.src2_sel = SRC2_IMM15_SL2;
				is_store = 1'b1;
			end
			OP_BEQ: begin
				ctrl.src2_sel = SRC2_RT;
				alu_op = ALU_SUB;
				ctrl.pc_sel = zero ? PC_BR14 : PC_PLUS4;
			end
			OP_J:    ctrl.pc_sel = PC_J24;
			OP_HALT: is_halt = 1'b1;
			default: ;
		endcase
	end

	always_comb begin
		fetch_req = '0;
		fetch_req.req = (state == FETCH);
		fetch_req.addr = pc;
		data_req = '0;
		data_req.req = (state == MEM);
		data_req.we = is_store;
		data_req.addr = alu_result[pc_width-1:0];
		data_req.wdata = store_data;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sequencing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			pc <= '0;
		end else begin
			case (state)
				IDLE:       if (core_run) state <= FETCH;
				FETCH:      if (fetch_grant) state <= FETCH_WAIT;
				FETCH_WAIT: if (fetch_rvalid) state <= EXEC;
				EXEC:       state <= (is_load || is_store) ? MEM : WB;
				MEM:        if (data_grant) state <= is_store ? WB : MEM_WAIT;
				MEM_WAIT:   if (data_rvalid) state <= WB;
				WB: begin
					pc <= next_pc;
					if (is_halt)
						state <= HALT;
					else if (core_run)
						state <= FETCH;
					else
						state <= IDLE;
				end
				HALT:       state <= HALT;
				default:    state <= IDLE;
			endcase
		end
	end

	// load data is caught on rvalid since a host read may overwrite the RAM output
	always_ff @(posedge clk) begin
		if (state == FETCH_WAIT && fetch_rvalid)
			ir <= mem_rdata;
		if ((state == EXEC && !is_load) || (state == MEM_WAIT && data_rvalid))
			wb_q <= wb_data;
	end

	assign rf_we = (state == WB) && writes_rd;
	assign current_pc = pc;
	assign halted = (state == HALT);

	always_comb begin
		retire.valid = (state == WB);
		retire.pc = pc;
		retire.we = rf_we;
		retire.rd = fields.rt;
		retire.data = wb_q;
	end

	assert property (@(posedge clk) disable iff (!rst_n) !(fetch_req.req && data_req.req))
		else $error("fetch and data request together");

	assert property (@(posedge clk) disable iff (!rst_n) fetch_grant |-> fetch_req.req)
		else $error("fetch grant without request");

	assert property (@(posedge clk) disable iff (!rst_n) data_grant |-> data_req.req)
		else $error("data grant without request");

endmodule

`default_nettype wire

// File: hdl/mem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
	input  logic                           clk,
	input  logic                           rst_n,
	input  cpu_pkg::mem_req_t              data_req,
	input  cpu_pkg::mem_req_t              host_req,
	input  cpu_pkg::mem_req_t              fetch_req,
	output logic                           data_grant,
	output logic                           host_grant,
	output logic                           fetch_grant,
	output logic                           data_rvalid,
	output logic                           host_rvalid,
	output logic                           fetch_rvalid,
	output cpu_pkg::mem_req_t              ram_req,
	input  logic [cpu_pkg::data_width-1:0] ram_rdata,
	output logic [cpu_pkg::data_width-1:0] rdata
);
	import cpu_pkg::*;

	// data first so a load or store never stalls behind the host
	assign data_grant = data_req.req;
	assign host_grant = host_req.req && !data_req.req;
	assign fetch_grant = fetch_req.req && !data_req.req && !host_req.req;

	always_comb begin
		if (data_grant)
			ram_req = data_req;
		else if (host_grant)
			ram_req = host_req;
		else if (fetch_grant)
			ram_req = fetch_req;
		else
			ram_req = '0;
	end

	// read owner kept for the one cycle of RAM latency
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data_rvalid <= 1'b0;
			host_rvalid <= 1'b0;
			fetch_rvalid <= 1'b0;
		end else begin
			data_rvalid <= data_grant && !data_req.we;
			host_rvalid <= host_grant && !host_req.we;
			fetch_rvalid <= fetch_grant && !fetch_req.we;
		end
	end

	assign rdata = ram_rdata;

	assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({data_grant, host_grant, fetch_grant}))
		else $error("more than one grant");

endmodule

`default_nettype wire

// File: hdl/unified_ram.sv
`timescale 1ns/1ns
`default_nettype none

module unified_ram (
	input  logic                           clk,
	input  cpu_pkg::mem_req_t              req,
	output logic [cpu_pkg::data_width-1:0] rdata
);
	import cpu_pkg::*;

	logic [data_width-1:0] mem [mem_words];
	logic [$clog2(mem_words)-1:0] index;

	// byte address, word storage
	assign index = req.addr[pc_width-1:2];

	always_ff @(posedge clk) begin
		if (req.req) begin
			if (req.we)
				mem[index] <= req.wdata;
			else
				rdata <= mem[index];
		end
	end

endmodule

`default_nettype wire

// File: hdl/cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_top (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           core_run,
	input  cpu_pkg::mem_req_t              host_req,
	output logic                           host_grant,
	output logic                           host_rvalid,
	output logic [cpu_pkg::data_width-1:0] host_rdata,
	output cpu_pkg::retire_t               retire,
	output logic                           halted
);
	import cpu_pkg::*;

	mem_req_t fetch_req;
	mem_req_t data_req;
	mem_req_t ram_req;
	logic fetch_grant;
	logic fetch_rvalid;
	logic data_grant;
	logic data_rvalid;
	logic [data_width-1:0] ram_rdata;
	logic [data_width-1:0] mem_rdata;
	logic [data_width-1:0] ra_data;
	logic [data_width-1:0] rb_data;
	logic [data_width-1:0] rt_data;
	logic [data_width-1:0] alu_result;
	logic [data_width-1:0] operand2;
	logic [data_width-1:0] wb_data;
	instr_fields_t fields;
	mux_ctrl_t ctrl;
	alu_op_t alu_op;
	logic zero;
	logic rf_we;
	logic [pc_width-1:0] next_pc;
	logic [pc_width-1:0] current_pc;

	assign host_rdata = mem_rdata;

	control_fsm ctrl0 (
		.clk(clk), .rst_n(rst_n), .core_run(core_run),
		.fetch_req(fetch_req), .data_req(data_req),
		.fetch_grant(fetch_grant), .fetch_rvalid(fetch_rvalid),
		.data_grant(data_grant), .data_rvalid(data_rvalid),
		.mem_rdata(mem_rdata), .fields(fields), .ctrl(ctrl), .alu_op(alu_op),
		.zero(zero), .next_pc(next_pc), .current_pc(current_pc), .rf_we(rf_we),
		.store_data(rt_data), .alu_result(alu_result), .wb_data(wb_data),
		.retire(retire), .halted(halted)
	);

	datapath_muxes mux0 (
		.current_pc(current_pc), .fields(fields), .ctrl(ctrl),
		.rb_data(rb_data), .rt_data(rt_data), .mem_rdata(mem_rdata),
		.alu_result(alu_result), .next_pc(next_pc), .operand2(operand2),
		.wb_data(wb_data)
	);

	alu alu0 (
		.op(alu_op), .a(ra_data), .b(operand2), .result(alu_result), .zero(zero)
	);

	// the retired value is the one written back
	register_file rf0 (
		.clk(clk), .rst_n(rst_n),
		.ra_addr(fields.ra), .rb_addr(fields.rb), .rt_addr(fields.rt),
		.ra_data(ra_data), .rb_data(rb_data), .rt_data(rt_data),
		.we(rf_we), .wr_addr(retire.rd), .wr_data(retire.data)
	);

	mem_arbiter arb0 (
		.clk(clk), .rst_n(rst_n),
		.data_req(data_req), .host_req(host_req), .fetch_req(fetch_req),
		.data_grant(data_grant), .host_grant(host_grant), .fetch_grant(fetch_grant),
		.data_rvalid(data_rvalid), .host_rvalid(host_rvalid),
		.fetch_rvalid(fetch_rvalid),
		.ram_req(ram_req), .ram_rdata(ram_rdata), .rdata(mem_rdata)
	);

	unified_ram ram0 (
		.clk(clk), .req(ram_req), .rdata(ram_rdata)
	);

endmodule

`default_nettype wire

// File: testbench/tb_cpu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cpu;
	import cpu_pkg::*;

	localparam int test_count = 6;
	localparam int max_prog = 24;
	localparam int data_base = 64;
	localparam int data_words = 32;

	logic clk;
	logic rst_n;
	logic core_run;
	mem_req_t host_req;
	logic host_grant;
	logic host_rvalid;
	logic [data_width-1:0] host_rdata;
	retire_t retire;
	logic halted;

	logic [data_width-1:0] prog [max_prog];
	logic [data_width-1:0] model_reg [reg_count];
	logic [data_width-1:0] model_mem [mem_words];
	logic [pc_width-1:0] model_pc;
	logic run_done;
	string test_name;
	int cycles;
	int cycle_limit;

	cpu_top dut0 (
		.clk(clk), .rst_n(rst_n), .core_run(core_run),
		.host_req(host_req), .host_grant(host_grant), .host_rvalid(host_rvalid),
		.host_rdata(host_rdata), .retire(retire), .halted(halted)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout: %0d cycles used with a limit of %0d", cycles, cycle_limit);
			$display("test failed");
			$fatal(1, "simulation stopped at the cycle limit");
		end
	end

	task automatic abort_run(input string reason);
		$display("%s: %s", test_name, reason);
		$display("test failed");
		$fatal(1, "simulation stopped after a failed check");
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("ERROR %s %s: expected %h, actual %h", test_name, what, expected, actual);
		$display("test failed");
		$fatal(1, "simulation stopped after a failed check");
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// program generation and ISA model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// branch and jump hops are counted in words and always point forward
	function automatic logic [31:0] make_instr(input int pos, input int len);
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [14:0] dw;
		int hop;
		rt = 5'($urandom_range(7, 0));
		ra = 5'($urandom_range(7, 0));
		rb = 5'($urandom_range(7, 0));
		dw = 15'(data_base + $urandom_range(data_words - 1, 0));
		hop = $urandom_range(len - 1 - pos, 1);
		case ($urandom_range(9, 0))
			0, 1: return {OP_ALU, 2'b00, rt, ra, rb, 2'($urandom_range(3, 0)), 3'b000,
				2'($urandom_range(2, 0)), 3'($urandom_range(5, 0))};
			2: return {OP_ADDI, 2'b00, rt, ra, 15'($urandom)};
			3: return {OP_ORI, 2'b00, rt, ra, 15'($urandom)};
			4: return {OP_ADDIU20, 2'b00, rt, 20'($urandom)};
			5: return {OP_SLLI, 2'b00, rt, ra, 15'($urandom)};
			6: return {OP_LWI, 2'b00, rt, 5'd0, dw};
			7: return {OP_SWI, 2'b00, rt, 5'd0, dw};
			8: begin
				if ($urandom_range(1, 0) == 0)
					ra = rt;
				return {OP_BEQ, 2'b00, rt, ra, 1'b0, 14'(2 * hop)};
			end
			default: return {OP_J, 3'b000, 24'(2 * hop)};
		endcase
	endfunction

	task automatic model_step(output logic exp_we, output logic [4:0] exp_rd,
			output logic [31:0] exp_data, output logic is_halt);
		logic [31:0] ir;
		logic [31:0] va;
		logic [31:0] vb;
		logic [31:0] vt;
		logic [31:0] b;
		logic [31:0] addr;
		logic [31:0] off;
		logic [pc_width-1:0] npc;
		ir = model_mem[model_pc[pc_width-1:2]];
		va = model_reg[ir[19:15]];
		vb = model_reg[ir[14:10]];
		vt = model_reg[ir[24:20]];
		exp_rd = ir[24:20];
		exp_we = 1'b1;
		exp_data = '0;
		is_halt = 1'b0;
		npc = model_pc + 10'd4;
		addr = va + {15'b0, ir[14:0], 2'b00};
		case (ir[31:27])
			OP_ALU: begin
				case (ir[4:3])
					2'b01:   b = vb << ir[9:8];
					2'b10:   b = vt;
					default: b = vb;
				endcase
				case (ir[2:0])
					ALU_SUB: exp_data = va - b;
					ALU_AND: exp_data = va & b;
					ALU_OR:  exp_data = va | b;
					ALU_XOR: exp_data = va ^ b;
					ALU_SLL: exp_data = va << b[4:0];
					default: exp_data = va + b;
				endcase
			end
			OP_ADDI:    exp_data = va + {{17{ir[14]}}, ir[14:0]};
			OP_ORI:     exp_data = va | {17'b0, ir[14:0]};
			OP_ADDIU20: exp_data = {{12{ir[19]}}, ir[19:0]};
			OP_SLLI:    exp_data = va << ir[14:10];
			OP_LWI:     exp_data = model_mem[addr[pc_width-1:2]];
			OP_SWI: begin
				model_mem[addr[pc_width-1:2]] = vt;
				exp_we = 1'b0;
			end
			OP_BEQ: begin
				exp_we = 1'b0;
				off = {{18{ir[13]}}, ir[13:0]} << 1;
				if (va == vt)
					npc = model_pc + off[pc_width-1:0];
			end
			OP_J: begin
				exp_we = 1'b0;
				off = {{8{ir[23]}}, ir[23:0]} << 1;
				npc = model_pc + off[pc_width-1:0];
			end
			OP_HALT: begin
				exp_we = 1'b0;
				is_halt = 1'b1;
			end
			default: exp_we = 1'b0;
		endcase
		if (exp_we && exp_rd != 5'd0)
			model_reg[exp_rd] = exp_data;
		model_pc = npc;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// host port and run phases
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// starts and ends 2 ns after a rising edge, outputs are sampled at the falling edge
	task automatic host_access(input logic we, input logic [pc_width-1:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		cycle_limit += 4;
		waited = 0;
		rdata = '0;
		host_req.req = 1'b1;
		host_req.we = we;
		host_req.addr = addr;
		host_req.wdata = wdata;
		@(negedge clk);
		while (!host_grant) begin
			waited++;
			@(negedge clk);
		end
		assert (core_run || waited == 0)
			else abort_run("host access was not granted at once with the core stopped");
		@(posedge clk);
		#2;
		host_req = '0;
		if (!we) begin
			@(negedge clk);
			assert (host_rvalid)
				else abort_run("host read data did not arrive one cycle after the grant");
			rdata = host_rdata;
			@(posedge clk);
			#2;
		end
	endtask

	task automatic follow_retires();
		logic [pc_width-1:0] exp_pc;
		logic exp_we;
		logic [4:0] exp_rd;
		logic [31:0] exp_data;
		logic done;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			assert (!halted) else abort_run("halted rose before the halt instruction retired");
			if (retire.valid) begin
				exp_pc = model_pc;
				model_step(exp_we, exp_rd, exp_data, done);
				assert (retire.pc == exp_pc) else report_mismatch("retire pc", exp_pc, retire.pc);
				assert (retire.we == exp_we) else report_mismatch("retire we", exp_we, retire.we);
				if (exp_we) begin
					assert (retire.rd == exp_rd)
						else report_mismatch("retire rd", exp_rd, retire.rd);
					assert (retire.data == exp_data)
						else report_mismatch("retire data", exp_data, retire.data);
				end
			end
		end
		@(negedge clk);
		assert (halted) else abort_run("halted did not rise in the cycle after halt retired");
		run_done = 1'b1;
	endtask

	// reads of the program area compete with instruction fetch
	task automatic mix_host_reads(input int len);
		int idx;
		int gap;
		logic [31:0] word;
		while (!run_done) begin
			gap = $urandom_range(2, 0);
			repeat (gap) begin
				@(posedge clk);
				#2;
			end
			if (!run_done) begin
				idx = $urandom_range(len - 1, 0);
				host_access(1'b0, pc_width'(idx * 4), '0, word);
				assert (word == prog[idx]) else report_mismatch("host read in run", prog[idx], word);
			end
		end
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		core_run = 1'b0;
		host_req = '0;
		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(negedge clk);
		assert (!retire.valid && !host_grant && !host_rvalid && !halted && retire.pc == '0)
			else abort_run("outputs are not idle after reset");
		@(posedge clk);
		#2;
	endtask

	task automatic run_test(input int t);
		logic [31:0] word;
		logic [31:0] fill;
		int len;
		test_name = $sformatf("random_program_%0d", t);
		len = $urandom_range(max_prog, 12);
		// forward-only branches bound the executed count by the program length
		cycle_limit += 16 + 12 * len;
		for (int i = 0; i < len - 1; i++)
			prog[i] = make_instr(i, len);
		prog[len - 1] = {OP_HALT, 27'b0};
		apply_reset();
		for (int i = 0; i < reg_count; i++)
			model_reg[i] = '0;
		model_pc = '0;
		for (int i = 0; i < len; i++) begin
			host_access(1'b1, pc_width'(i * 4), prog[i], word);
			model_mem[i] = prog[i];
		end
		for (int w = data_base; w < data_base + data_words; w++) begin
			fill = $urandom;
			host_access(1'b1, pc_width'(w * 4), fill, word);
			model_mem[w] = fill;
		end

		run_done = 1'b0;
		core_run = 1'b1;
		fork
			follow_retires();
			mix_host_reads(len);
		join
		@(posedge clk);
		#2;
		core_run = 1'b0;

		repeat (4) begin
			@(negedge clk);
			assert (halted && !retire.valid && !host_grant && !dut0.fetch_grant && !dut0.data_grant)
				else abort_run("core is not quiet after halt");
		end
		@(posedge clk);
		#2;
		for (int w = data_base; w < data_base + data_words; w++) begin
			host_access(1'b0, pc_width'(w * 4), '0, word);
			assert (word == model_mem[w])
				else report_mismatch($sformatf("data word %0d", w), model_mem[w], word);
		end
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		core_run = 1'b0;
		host_req = '0;
		run_done = 1'b0;
		cycles = 0;
		cycle_limit = 0;
		void'($urandom(32'hd8580cad));
		for (int t = 0; t < test_count; t++)
			run_test(t);
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
hdl/cpu_pkg.sv
hdl/alu.sv
hdl/register_file.sv
hdl/datapath_muxes.sv
hdl/control_fsm.sv
hdl/mem_arbiter.sv
hdl/unified_ram.sv
hdl/cpu_top.sv
testbench/tb_cpu.sv

// File: Bender.yml
package:
  name: multicycle_cpu

sources:
  - hdl/cpu_pkg.sv
  - hdl/alu.sv
  - hdl/register_file.sv
  - hdl/datapath_muxes.sv
  - hdl/control_fsm.sv
  - hdl/mem_arbiter.sv
  - hdl/unified_ram.sv
  - hdl/cpu_top.sv
  - target: test
    files:
      - testbench/tb_cpu.sv
